// File: src.f
logic/sld_pkg.sv
logic/sld_seq.sv
logic/sld_operand.sv
logic/sld_shift.sv
logic/sld_writeback.sv
logic/sld_unit.sv
tests/sld_tb.sv

// File: tests/sld_patterns.hex
// mode dir slide1 sew vl rs1 vs2 vd id | vs2 data | old vd data | expected vd (128 bit hex)
// mode 1 issues the line and the next one back to back
0 0 0 0 10 00000000 02 03 0 1f1e1d1c1b1a19181716151413121110 afaeadacabaaa9a8a7a6a5a4a3a2a1a0 1f1e1d1c1b1a19181716151413121110
0 0 0 0 10 00000001 02 03 1 1f1e1d1c1b1a19181716151413121110 afaeadacabaaa9a8a7a6a5a4a3a2a1a0 1e1d1c1b1a19181716151413121110a0
0 0 0 0 10 00000003 02 03 2 1f1e1d1c1b1a19181716151413121110 afaeadacabaaa9a8a7a6a5a4a3a2a1a0 1c1b1a19181716151413121110a2a1a0
0 0 0 0 10 00000005 02 03 3 1f1e1d1c1b1a19181716151413121110 afaeadacabaaa9a8a7a6a5a4a3a2a1a0 1a19181716151413121110a4a3a2a1a0
0 0 0 1 08 00000000 04 05 4 1f1e1d1c1b1a19181716151413121110 afaeadacabaaa9a8a7a6a5a4a3a2a1a0 1f1e1d1c1b1a19181716151413121110
0 0 0 1 08 00000001 04 05 5 1f1e1d1c1b1a19181716151413121110 afaeadacabaaa9a8a7a6a5a4a3a2a1a0 1d1c1b1a19181716151413121110a1a0
0 0 0 1 08 00000003 04 05 6 1f1e1d1c1b1a19181716151413121110 afaeadacabaaa9a8a7a6a5a4a3a2a1a0 19181716151413121110a5a4a3a2a1a0
0 0 0 1 08 00000005 04 05 7 1f1e1d1c1b1a19181716151413121110 afaeadacabaaa9a8a7a6a5a4a3a2a1a0 151413121110a9a8a7a6a5a4a3a2a1a0
0 0 0 2 04 00000000 00 1f 0 1f1e1d1c1b1a19181716151413121110 afaeadacabaaa9a8a7a6a5a4a3a2a1a0 1f1e1d1c1b1a19181716151413121110
0 0 0 2 04 00000001 00 1f 1 1f1e1d1c1b1a19181716151413121110 afaeadacabaaa9a8a7a6a5a4a3a2a1a0 1b1a19181716151413121110a3a2a1a0
0 0 0 2 04 00000003 00 1f 2 1f1e1d1c1b1a19181716151413121110 afaeadacabaaa9a8a7a6a5a4a3a2a1a0 13121110abaaa9a8a7a6a5a4a3a2a1a0
0 0 0 2 04 00000005 00 1f 3 1f1e1d1c1b1a19181716151413121110 afaeadacabaaa9a8a7a6a5a4a3a2a1a0 afaeadacabaaa9a8a7a6a5a4a3a2a1a0
0 1 0 0 10 00000003 0a 0b 4 1f1e1d1c1b1a19181716151413121110 afaeadacabaaa9a8a7a6a5a4a3a2a1a0 0000001f1e1d1c1b1a19181716151413
0 1 0 1 08 00000005 0a 0b 5 1f1e1d1c1b1a19181716151413121110 afaeadacabaaa9a8a7a6a5a4a3a2a1a0 000000000000000000001f1e1d1c1b1a
0 1 0 2 04 00000001 0a 0b 6 1f1e1d1c1b1a19181716151413121110 afaeadacabaaa9a8a7a6a5a4a3a2a1a0 000000001f1e1d1c1b1a191817161514
0 1 0 2 04 00000005 0a 0b 7 1f1e1d1c1b1a19181716151413121110 afaeadacabaaa9a8a7a6a5a4a3a2a1a0 00000000000000000000000000000000
0 0 1 0 10 5a6b7c8d 0c 0d 0 1f1e1d1c1b1a19181716151413121110 afaeadacabaaa9a8a7a6a5a4a3a2a1a0 1e1d1c1b1a191817161514131211108d
0 0 1 1 08 5a6b7c8d 0c 0d 1 1f1e1d1c1b1a19181716151413121110 afaeadacabaaa9a8a7a6a5a4a3a2a1a0 1d1c1b1a191817161514131211107c8d
0 0 1 2 04 5a6b7c8d 0c 0d 2 1f1e1d1c1b1a19181716151413121110 afaeadacabaaa9a8a7a6a5a4a3a2a1a0 1b1a191817161514131211105a6b7c8d
0 1 1 0 10 5a6b7c8d 0c 0d 3 1f1e1d1c1b1a19181716151413121110 afaeadacabaaa9a8a7a6a5a4a3a2a1a0 8d1f1e1d1c1b1a191817161514131211
0 1 1 1 08 5a6b7c8d 0c 0d 4 1f1e1d1c1b1a19181716151413121110 afaeadacabaaa9a8a7a6a5a4a3a2a1a0 7c8d1f1e1d1c1b1a1918171615141312
0 1 1 2 04 5a6b7c8d 0c 0d 5 1f1e1d1c1b1a19181716151413121110 afaeadacabaaa9a8a7a6a5a4a3a2a1a0 5a6b7c8d1f1e1d1c1b1a191817161514
0 1 1 1 05 5a6b7c8d 0c 0d 6 1f1e1d1c1b1a19181716151413121110 afaeadacabaaa9a8a7a6a5a4a3a2a1a0 afaeadacabaa7c8d1918171615141312
0 0 0 0 09 00000002 10 11 7 1f1e1d1c1b1a19181716151413121110 afaeadacabaaa9a8a7a6a5a4a3a2a1a0 afaeadacabaaa916151413121110a1a0
0 1 0 2 02 00000001 10 11 0 1f1e1d1c1b1a19181716151413121110 afaeadacabaaa9a8a7a6a5a4a3a2a1a0 afaeadacabaaa9a81b1a191817161514
0 0 0 0 00 00000001 10 11 1 1f1e1d1c1b1a19181716151413121110 afaeadacabaaa9a8a7a6a5a4a3a2a1a0 afaeadacabaaa9a8a7a6a5a4a3a2a1a0
1 0 0 1 08 00000001 06 07 2 1f1e1d1c1b1a19181716151413121110 afaeadacabaaa9a8a7a6a5a4a3a2a1a0 1d1c1b1a19181716151413121110a1a0
0 1 0 0 10 00000005 08 09 3 1f1e1d1c1b1a19181716151413121110 afaeadacabaaa9a8a7a6a5a4a3a2a1a0 00000000001f1e1d1c1b1a1918171615

// File: tests/sld_tb.sv
// slide unit testbench
// runs the operations of the pattern file against a register-file model

`default_nettype none

module sld_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_OPS  = 28;
    localparam int FIELDS   = 12;    // entries per pattern line
    localparam int F_SRC    = 9;
    localparam int F_OLD    = 10;
    localparam int F_EXP    = 11;
    localparam int TIMEOUT  = 50;    // cycles per wait
    localparam int DONE_LAT = 8;     // ack edge to write and done

    logic               clk = 1'b0;
    logic               rst_n;
    logic               op_rdy;
    sld_pkg::sld_op_t   op;
    logic               op_ack;
    sld_pkg::vaddr_t    rd_addr;
    sld_pkg::vreg_t     rd_data;
    logic               wr_en;
    sld_pkg::vaddr_t    wr_addr;
    sld_pkg::vreg_t     wr_data;
    sld_pkg::vmask_t    wr_be;
    logic               done_valid;
    sld_pkg::id_t       done_id;

    sld_pkg::vreg_t     rf [32];
    logic [127:0]       pat_mem [NUM_OPS*FIELDS];

    always #2 clk = ~clk;

    sld_unit sld_unit_i (
        .clk_i          (clk),
        .async_rst_ni   (rst_n),
        .op_rdy_i       (op_rdy),
        .op_i           (op),
        .op_ack_o       (op_ack),
        .vreg_rd_addr_o (rd_addr),
        .vreg_rd_i      (rd_data),
        .vreg_wr_en_o   (wr_en),
        .vreg_wr_addr_o (wr_addr),
        .vreg_wr_o      (wr_data),
        .vreg_wr_be_o   (wr_be),
        .done_valid_o   (done_valid),
        .done_id_o      (done_id)
    );

    ////////////////////
    // register file model

    assign rd_data = rf[rd_addr];   // combinational read

    always @(posedge clk) begin
        if (wr_en) begin
            for (int b = 0; b < sld_pkg::VREG_BYTES; b++) begin
                if (wr_be[b]) begin
                    rf[wr_addr][b*8 +: 8] <= wr_data[b*8 +: 8];
                end
            end
        end
    end

    ////////////////////
    // helpers

    task automatic stop_run();
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [127:0] exp,
                               input logic [127:0] act);
        if (act !== exp) begin
            $display("FAILED %s: expected %0h, actual %0h", name, exp, act);
            stop_run();
        end
    endtask

    task automatic timeout_error(input string what);
        $display("timeout while waiting for %s", what);
        stop_run();
    endtask

    function automatic sld_pkg::sld_op_t op_from_line(input int n);
        sld_pkg::sld_op_t op_val;
        int               base;
        base          = n * FIELDS;
        op_val.dir    = sld_pkg::sld_dir_e'(pat_mem[base+1][0]);
        op_val.slide1 = pat_mem[base+2][0];
        op_val.sew    = sld_pkg::sew_e'(pat_mem[base+3][1:0]);
        op_val.vl     = pat_mem[base+4][4:0];
        op_val.rs1    = pat_mem[base+5][31:0];
        op_val.vs2    = pat_mem[base+6][4:0];
        op_val.vd     = pat_mem[base+7][4:0];
        op_val.id     = pat_mem[base+8][2:0];
        return op_val;
    endfunction

    // source and old destination into the model, DUT idle
    task automatic load_regs(input int n);
        rf[pat_mem[n*FIELDS+6][4:0]] = pat_mem[n*FIELDS+F_SRC];
        rf[pat_mem[n*FIELDS+7][4:0]] = pat_mem[n*FIELDS+F_OLD];
    endtask

    task automatic check_result(input int n);
        check_value($sformatf("op %0d vd", n), pat_mem[n*FIELDS+F_EXP],
                    rf[pat_mem[n*FIELDS+7][4:0]]);
    endtask

    // cycles counts negedges up to and including the one with ack high
    task automatic wait_ack(output int cycles);
        logic seen;
        cycles = 0;
        seen   = 1'b0;
        while (!seen) begin
            @(negedge clk);
            cycles++;
            seen = op_ack;
            if (!seen && cycles >= TIMEOUT) timeout_error("op_ack_o");
        end
    endtask

    // the write must come in the same cycle as done
    task automatic wait_done(output sld_pkg::id_t id, output int cycles);
        logic seen;
        cycles = 0;
        seen   = 1'b0;
        while (!seen) begin
            @(negedge clk);
            cycles++;
            seen = done_valid;
            if (!seen && cycles >= TIMEOUT) timeout_error("done_valid_o");
        end
        check_value("vreg_wr_en_o with done", 1'b1, wr_en);
        id = done_id;
    endtask

    task automatic run_single(input int n);
        int           cycles;
        sld_pkg::id_t id;
        load_regs(n);
        @(posedge clk);
        op     <= op_from_line(n);
        op_rdy <= 1'b1;
        wait_ack(cycles);
        @(posedge clk);             // op taken here
        op_rdy <= 1'b0;
        wait_done(id, cycles);
        check_value($sformatf("op %0d done cycle", n), DONE_LAT, cycles);
        check_value($sformatf("op %0d done id", n), pat_mem[n*FIELDS+8], id);
        @(posedge clk);             // model takes the write
        @(negedge clk);
        check_result(n);
    endtask

    // second op offered right after the first is taken
    task automatic run_pair(input int n);
        int           cycles;
        sld_pkg::id_t id;
        load_regs(n);
        load_regs(n + 1);
        @(posedge clk);
        op     <= op_from_line(n);
        op_rdy <= 1'b1;
        wait_ack(cycles);
        @(posedge clk);
        op <= op_from_line(n + 1);
        wait_ack(cycles);
        check_value($sformatf("op %0d ack cycle", n + 1), sld_pkg::CHUNKS + 1, cycles);
        @(posedge clk);
        op_rdy <= 1'b0;
        wait_done(id, cycles);
        check_value($sformatf("op %0d done id", n), pat_mem[n*FIELDS+8], id);
        wait_done(id, cycles);
        check_value($sformatf("op %0d done id", n + 1), pat_mem[(n+1)*FIELDS+8], id);
        @(posedge clk);
        @(negedge clk);
        check_result(n);
        check_result(n + 1);
    endtask

    ////////////////////
    // main sequence

    initial begin : main
        int n;
        rst_n  = 1'b0;
        op_rdy = 1'b0;
        op     = '0;
        for (int a = 0; a < 32; a++) begin
            rf[a] = {16{8'(a * 37 + 5)}};
        end
        $readmemh("tests/sld_patterns.hex", pat_mem);
        if ($isunknown(pat_mem[NUM_OPS*FIELDS-1])) begin
            $display("pattern file could not be read completely");
            stop_run();
        end

        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        // quiet outputs while nothing is offered
        repeat (3) begin
            @(negedge clk);
            check_value("idle op_ack_o", 1'b0, op_ack);
            check_value("idle vreg_wr_en_o", 1'b0, wr_en);
            check_value("idle done_valid_o", 1'b0, done_valid);
        end

        n = 0;
        while (n < NUM_OPS) begin
            if (pat_mem[n*FIELDS][0]) begin
                run_pair(n);
                n += 2;
            end else begin
                run_single(n);
                n += 1;
            end
        end

        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: logic/sld_unit.sv
// vector slide unit top
// sequencer, operand, shift and writeback stages in a row

`default_nettype none

module sld_unit (
    input  wire logic                clk_i,
    input  wire logic                async_rst_ni,
    input  wire logic                op_rdy_i,
    input  wire sld_pkg::sld_op_t    op_i,
    output logic                     op_ack_o,
    output sld_pkg::vaddr_t          vreg_rd_addr_o,
    input  wire sld_pkg::vreg_t      vreg_rd_i,
    output logic                     vreg_wr_en_o,
    output sld_pkg::vaddr_t          vreg_wr_addr_o,
    output sld_pkg::vreg_t           vreg_wr_o,
    output sld_pkg::vmask_t          vreg_wr_be_o,
    output logic                     done_valid_o,
    output sld_pkg::id_t             done_id_o
);

    logic               step_valid;
    sld_pkg::sld_step_t step;
    logic               opnd_valid;
    sld_pkg::sld_step_t opnd_step;
    sld_pkg::chunk_t    low_q;
    sld_pkg::chunk_t    high_q;
    logic               low_ok;
    logic               high_ok;
    logic               res_valid;
    sld_pkg::sld_step_t res_step;
    sld_pkg::chunk_t    res;
    sld_pkg::cmask_t    res_be;

    sld_seq sld_seq_i (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .op_rdy_i     (op_rdy_i),
        .op_i         (op_i),
        .op_ack_o     (op_ack_o),
        .step_valid_o (step_valid),
        .step_o       (step)
    );

    sld_operand sld_operand_i (
        .clk_i          (clk_i),
        .async_rst_ni   (async_rst_ni),
        .step_valid_i   (step_valid),
        .step_i         (step),
        .vreg_rd_i      (vreg_rd_i),
        .vreg_rd_addr_o (vreg_rd_addr_o),
        .opnd_valid_o   (opnd_valid),
        .opnd_step_o    (opnd_step),
        .low_o          (low_q),
        .high_o         (high_q),
        .low_ok_o       (low_ok),
        .high_ok_o      (high_ok)
    );

    sld_shift sld_shift_i (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .opnd_valid_i (opnd_valid),
        .opnd_step_i  (opnd_step),
        .low_i        (low_q),
        .high_i       (high_q),
        .low_ok_i     (low_ok),
        .high_ok_i    (high_ok),
        .res_valid_o  (res_valid),
        .res_step_o   (res_step),
        .res_o        (res),
        .res_be_o     (res_be)
    );

    sld_writeback sld_writeback_i (
        .clk_i          (clk_i),
        .async_rst_ni   (async_rst_ni),
        .res_valid_i    (res_valid),
        .res_step_i     (res_step),
        .res_i          (res),
        .res_be_i       (res_be),
        .vreg_wr_en_o   (vreg_wr_en_o),
        .vreg_wr_addr_o (vreg_wr_addr_o),
        .vreg_wr_o      (vreg_wr_o),
        .vreg_wr_be_o   (vreg_wr_be_o),
        .done_valid_o   (done_valid_o),
        .done_id_o      (done_id_o)
    );

endmodule

`default_nettype wire

// File: logic/sld_writeback.sv
// slide writeback
// gathers result chunks into one register write and reports completion

`default_nettype none

module sld_writeback (
    input  wire logic                clk_i,
    input  wire logic                async_rst_ni,
    input  wire logic                res_valid_i,
    input  wire sld_pkg::sld_step_t  res_step_i,
    input  wire sld_pkg::chunk_t     res_i,
    input  wire sld_pkg::cmask_t     res_be_i,
    output logic                     vreg_wr_en_o,
    output sld_pkg::vaddr_t          vreg_wr_addr_o,
    output sld_pkg::vreg_t           vreg_wr_o,
    output sld_pkg::vmask_t          vreg_wr_be_o,
    output logic                     done_valid_o,
    output sld_pkg::id_t             done_id_o
);

    sld_pkg::vreg_t     wb_data_q;
    sld_pkg::vmask_t    wb_be_q;
    sld_pkg::byte_off_t vlb;
    sld_pkg::vmask_t    vl_mask;
    logic [1:0]         slot;
    logic               issue;

    assign slot    = res_step_i.count[1:0] - 2'd1;     // counts 1..4 map to 0..3
    assign vlb     = sld_pkg::vl_bytes(res_step_i.op.vl, res_step_i.op.sew);
    assign vl_mask = sld_pkg::vmask_t'((17'd1 << vlb) - 17'd1);
    assign issue   = res_valid_i && res_step_i.last;

    // bytes at and above vl keep the old value
    always_ff @(posedge clk_i) begin
        if (res_valid_i) begin
            wb_data_q[slot*sld_pkg::OP_W +: sld_pkg::OP_W] <= res_i;
            wb_be_q[slot*sld_pkg::CHUNK_BYTES +: sld_pkg::CHUNK_BYTES] <=
                res_be_i & vl_mask[slot*sld_pkg::CHUNK_BYTES +: sld_pkg::CHUNK_BYTES];
        end
        if (issue) begin
            vreg_wr_addr_o <= res_step_i.op.vd;
            done_id_o      <= res_step_i.op.id;
        end
    end

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            vreg_wr_en_o <= 1'b0;
            done_valid_o <= 1'b0;
        end else begin
            vreg_wr_en_o <= issue;   // fires even with no enabled byte
            done_valid_o <= issue;
        end
    end

    assign vreg_wr_o    = wb_data_q;
    assign vreg_wr_be_o = wb_be_q;

    // write and done leave together, one cycle per operation
    a_write_with_done : assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        (vreg_wr_en_o || done_valid_o) |-> (vreg_wr_en_o && done_valid_o) ##1 !vreg_wr_en_o);

endmodule

`default_nettype wire

// File: logic/sld_shift.sv
// slide byte shifter
// joins low and high operands into one result chunk with byte valid flags

`default_nettype none

module sld_shift (
    input  wire logic                clk_i,
    input  wire logic                async_rst_ni,
    input  wire logic                opnd_valid_i,
    input  wire sld_pkg::sld_step_t  opnd_step_i,
    input  wire sld_pkg::chunk_t     low_i,
    input  wire sld_pkg::chunk_t     high_i,
    input  wire logic                low_ok_i,
    input  wire logic                high_ok_i,
    output logic                     res_valid_o,
    output sld_pkg::sld_step_t       res_step_o,
    output sld_pkg::chunk_t          res_o,
    output sld_pkg::cmask_t          res_be_o
);

    sld_pkg::chunk_t res_d;
    sld_pkg::cmask_t be_d;

    always_comb begin : byte_select
        int sel;
        res_d = '0;
        be_d  = '0;
        for (int b = 0; b < sld_pkg::CHUNK_BYTES; b++) begin
            if (2'(b) < opnd_step_i.shift) begin
                sel             = b + sld_pkg::CHUNK_BYTES - int'(opnd_step_i.shift);
                res_d[b*8 +: 8] = low_i[sel*8 +: 8];
                be_d[b]         = low_ok_i;
            end else begin
                sel             = b - int'(opnd_step_i.shift);
                res_d[b*8 +: 8] = high_i[sel*8 +: 8];
                be_d[b]         = high_ok_i;
            end
        end
    end

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            res_valid_o <= 1'b0;
        end else begin
            res_valid_o <= opnd_valid_i && !opnd_step_i.first;   // priming step drops out
        end
    end

    always_ff @(posedge clk_i) begin
        if (opnd_valid_i) begin
            res_step_o <= opnd_step_i;
            res_o      <= res_d;
            res_be_o   <= be_d;
        end
    end

endmodule

`default_nettype wire

// File: logic/sld_operand.sv
// slide operand stage
// fetches one source chunk per step and keeps the previous one as low operand

`default_nettype none

module sld_operand (
    input  wire logic                clk_i,
    input  wire logic                async_rst_ni,
    input  wire logic                step_valid_i,
    input  wire sld_pkg::sld_step_t  step_i,
    input  wire sld_pkg::vreg_t      vreg_rd_i,
    output sld_pkg::vaddr_t          vreg_rd_addr_o,
    output logic                     opnd_valid_o,
    output sld_pkg::sld_step_t       opnd_step_o,
    output sld_pkg::chunk_t          low_o,
    output sld_pkg::chunk_t          high_o,
    output logic                     low_ok_o,
    output logic                     high_ok_o
);

    sld_pkg::chunk_t    rs1_rep;    // rs1 element across the chunk
    sld_pkg::chunk_t    fetch;
    logic               fetch_ok;
    sld_pkg::byte_off_t vlb;
    logic [2:0]         elem_b;

    assign vreg_rd_addr_o = step_i.op.vs2;  // chunk picked by src_idx below

    always_comb begin
        case (step_i.op.sew)
            sld_pkg::SEW_8:  rs1_rep = {4{step_i.op.rs1[7:0]}};
            sld_pkg::SEW_16: rs1_rep = {2{step_i.op.rs1[15:0]}};
            default:         rs1_rep = step_i.op.rs1;
        endcase
    end

    assign vlb    = sld_pkg::vl_bytes(step_i.op.vl, step_i.op.sew);
    assign elem_b = 3'd1 << step_i.op.sew;

    always_comb begin : fetch_chunk
        fetch    = '0;
        fetch_ok = (step_i.op.dir == sld_pkg::SLD_DOWN);   // zero fill past the top
        if (step_i.src_valid) begin
            fetch    = vreg_rd_i[step_i.src_idx * sld_pkg::OP_W +: sld_pkg::OP_W];
            fetch_ok = 1'b1;
        end else if (step_i.op.slide1 && step_i.op.dir == sld_pkg::SLD_UP) begin
            fetch    = rs1_rep;     // below element 0
            fetch_ok = 1'b1;
        end
        // slide-one down: source element vl is rs1, it lands on element vl-1
        // the source chunk index equals count here
        if (step_i.op.slide1 && step_i.op.dir == sld_pkg::SLD_DOWN &&
                step_i.count == vlb[4:2]) begin
            for (int b = 0; b < sld_pkg::CHUNK_BYTES; b++) begin
                if (3'(b) >= {1'b0, vlb[1:0]} && 3'(b) < {1'b0, vlb[1:0]} + elem_b) begin
                    fetch[b*8 +: 8] = rs1_rep[b*8 +: 8];
                end
            end
        end
    end

    ////////////////////
    // stage registers

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            opnd_valid_o <= 1'b0;
        end else begin
            opnd_valid_o <= step_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (step_valid_i) begin
            opnd_step_o <= step_i;
            high_o      <= fetch;
            high_ok_o   <= fetch_ok;
            low_o       <= high_o;      // previous fetch
            low_ok_o    <= high_ok_o;
        end
    end

endmodule

`default_nettype wire

// File: logic/sld_seq.sv
// slide sequencer
// takes one operation and walks it through the register chunk by chunk

`default_nettype none

module sld_seq (
    input  wire logic               clk_i,
    input  wire logic               async_rst_ni,
    input  wire logic               op_rdy_i,
    input  wire sld_pkg::sld_op_t   op_i,
    output logic                    op_ack_o,
    output logic                    step_valid_o,
    output sld_pkg::sld_step_t      step_o
);

    sld_pkg::seq_state_e state_q;
    sld_pkg::sld_op_t    op_q;
    logic [2:0]          cnt_q;
    logic [3:0]          q_q;       // chunk part of the signed offset
    logic [1:0]          r_q;       // byte part
    logic                last_step;

    sld_pkg::byte_off_t  k;
    logic [5:0]          koff;      // two's complement, negative for down
    logic [4:0]          src_idx;   // two's complement, range -5..7

    ////////////////////
    // offset of the incoming op

    always_comb begin : offset_calc
        logic [6:0] kb;
        if (op_i.slide1) begin
            kb = 7'd1 << op_i.sew;               // one element
        end else if (op_i.rs1 > 32'd16) begin
            kb = 7'd16;
        end else begin
            kb = op_i.rs1[6:0] << op_i.sew;
        end
        k = (kb > 7'd16) ? 5'd16 : kb[4:0];
        // down slides run as an up slide by -k
        koff = (op_i.dir == sld_pkg::SLD_UP) ? {1'b0, k} : 6'd0 - {1'b0, k};
    end

    ////////////////////
    // state machine

    assign last_step = (state_q == sld_pkg::RUN) && (cnt_q == 3'(sld_pkg::CHUNKS));
    assign op_ack_o  = op_rdy_i && ((state_q == sld_pkg::IDLE) || last_step);

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            state_q <= sld_pkg::IDLE;
            cnt_q   <= '0;
        end else if (op_ack_o) begin
            state_q <= sld_pkg::RUN;
            cnt_q   <= '0;
        end else if (state_q == sld_pkg::RUN) begin
            cnt_q <= last_step ? 3'd0 : cnt_q + 3'd1;
            if (last_step) begin
                state_q <= sld_pkg::IDLE;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (op_ack_o) begin
            op_q <= op_i;
            q_q  <= koff[5:2];
            r_q  <= koff[1:0];
        end
    end

    // source chunk for result chunk cnt-1
    assign src_idx = {2'b00, cnt_q} - 5'd1 - {q_q[3], q_q};

    always_comb begin
        step_o.count     = cnt_q;
        step_o.src_valid = (src_idx[4:2] == 3'b000);  // 0..3 only
        step_o.src_idx   = src_idx[1:0];
        step_o.shift     = r_q;
        step_o.first     = (cnt_q == 3'd0);
        step_o.last      = (cnt_q == 3'(sld_pkg::CHUNKS));
        step_o.op        = op_q;
    end

    assign step_valid_o = (state_q == sld_pkg::RUN);

    // a new op only overlaps the final step of the current one
    a_ack_in_last_step : assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        (op_ack_o && state_q == sld_pkg::RUN) |-> $past(op_ack_o, sld_pkg::CHUNKS + 1));

endmodule

`default_nettype wire

// File: logic/sld_pkg.sv
// vector slide unit shared definitions
// widths, value types, enums and the op/step structs

`default_nettype none

package sld_pkg;

    ////////////////////
    // widths

    localparam int unsigned VREG_W      = 128;          // vector register
    localparam int unsigned OP_W        = 32;           // one chunk
    localparam int unsigned CHUNKS      = VREG_W / OP_W;
    localparam int unsigned VREG_BYTES  = VREG_W / 8;
    localparam int unsigned CHUNK_BYTES = OP_W / 8;
    localparam int unsigned ID_W        = 3;

    ////////////////////
    // value types

    typedef logic [VREG_W-1:0]      vreg_t;
    typedef logic [VREG_BYTES-1:0]  vmask_t;    // byte enables, one register
    typedef logic [OP_W-1:0]        chunk_t;
    typedef logic [CHUNK_BYTES-1:0] cmask_t;
    typedef logic [4:0]             vaddr_t;
    typedef logic [ID_W-1:0]        id_t;
    typedef logic [4:0]             vl_t;       // 0 to 16 elements
    typedef logic [4:0]             byte_off_t; // 16 is the whole register

    typedef enum logic [1:0] {
        SEW_8  = 2'd0,
        SEW_16 = 2'd1,
        SEW_32 = 2'd2
    } sew_e;

    typedef enum logic {
        SLD_UP   = 1'b0,
        SLD_DOWN = 1'b1
    } sld_dir_e;

    typedef enum logic {
        IDLE = 1'b0,
        RUN  = 1'b1
    } seq_state_e;

    typedef struct packed {
        sld_dir_e    dir;
        logic        slide1;
        sew_e        sew;
        vl_t         vl;
        logic [31:0] rs1;    // scalar offset or slide-one value
        vaddr_t      vs2;
        vaddr_t      vd;
        id_t         id;
    } sld_op_t;

    typedef struct packed {
        logic [2:0] count;     // 0 is the priming step
        logic       src_valid; // fetched chunk is inside the register
        logic [1:0] src_idx;
        logic [1:0] shift;     // byte part of the offset
        logic       first;
        logic       last;
        sld_op_t    op;
    } sld_step_t;

    // vl in bytes, saturated at one register
    function automatic byte_off_t vl_bytes(input vl_t vl, input sew_e sew);
        logic [6:0] b;
        b = 7'(vl) << sew;
        return (b > 7'd16) ? 5'd16 : b[4:0];
    endfunction

endpackage

`default_nettype wire
